// File: bench/mmu_assertions.sv
module mmu_assertions (
    input logic                     clk,
    input logic                     rstn,
    input logic                     req_valid,
    input logic                     req_ready,
    input logic                     fill_valid,
    input logic                     rsp_valid,
    input logic                     rsp_ready,
    input logic                     rsp_hit,
    input logic                     rsp_fault,
    input logic [mmu_pkg::PA_W-1:0] rsp_pa
);

    // payload frozen under back-pressure.
    stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable({rsp_hit, rsp_fault, rsp_pa}))
        else $error("response payload changed while stalled");

    rsp_after_req: assert property (@(posedge clk) disable iff (!rstn)
        req_valid && req_ready |=> rsp_valid)
        else $error("no response one cycle after an accepted request");

    fill_priority: assert property (@(posedge clk) disable iff (!rstn)
        fill_valid |-> !req_ready)
        else $error("request ready while a fill is pending");

endmodule

bind mmu_translate mmu_assertions u_assertions (
    .clk        (clk),
    .rstn       (rstn),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .fill_valid (fill_valid),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp_hit    (rsp_hit),
    .rsp_fault  (rsp_fault),
    .rsp_pa     (rsp_pa)
);

// File: bench/mmu_checker.sv
module mmu_checker #(
    parameter int TLB_SETS   = 32,
    parameter int TLB_WAYS   = 4,
    parameter int SP_ENTRIES = 4
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      req_valid,
    input  logic                      req_ready,
    input  logic [mmu_pkg::VA_W-1:0]  req_va,
    input  logic                      req_write,
    input  logic                      fill_valid,
    input  logic                      fill_ready,
    input  logic [mmu_pkg::VA_W-1:0]  fill_va,
    input  logic [mmu_pkg::PTE_W-1:0] fill_pte,
    input  logic                      fill_mega,
    input  logic                      rsp_valid,
    input  logic                      rsp_ready,
    input  logic                      rsp_hit,
    input  logic [mmu_pkg::PA_W-1:0]  rsp_pa,
    input  logic                      rsp_fault,
    output int                        checks,
    output int                        errors,
    output int                        pending
);
    import mmu_pkg::*;

    // shadow of both caches, oldest fill at index 0.
    logic [VPN_W-1:0]  k_vpn [TLB_SETS][TLB_WAYS];
    logic [PTE_W-1:0]  k_pte [TLB_SETS][TLB_WAYS];
    int                k_cnt [TLB_SETS];
    logic [VPN1_W-1:0] m_vpn1 [SP_ENTRIES];
    logic [PTE_W-1:0]  m_pte [SP_ENTRIES];
    int                m_cnt;
    logic [35:0]       exp_q [$];  // {hit, fault, pa}.
    logic [35:0]       want;
    int                idx;

    function automatic logic [35:0] expect_xlate(input logic [31:0] va, input logic write);
        logic [31:0] pte;
        logic        hit;
        logic        mega;
        int          set_idx;
        hit = 1'b0;
        mega = 1'b0;
        pte = '0;
        set_idx = int'(va[31:12]) % TLB_SETS;
        for (int i = 0; i < m_cnt; i++) begin
            if (m_vpn1[i] == va[31:22]) begin
                hit = 1'b1;
                mega = 1'b1;
                pte = m_pte[i];
            end
        end
        for (int i = 0; i < k_cnt[set_idx]; i++) begin
            if (!mega && k_vpn[set_idx][i] == va[31:12]) begin
                hit = 1'b1;
                pte = k_pte[set_idx][i];
            end
        end
        if (!hit) begin
            return '0;  // miss gives zero address, no fault.
        end
        return {1'b1, !pte[0] || (write && !pte[2]),
                mega ? {pte[31:20], va[21:0]} : {pte[31:10], va[11:0]}};
    endfunction

    always @(posedge clk) begin
        if (!rstn) begin
            m_cnt = 0;
            for (int s = 0; s < TLB_SETS; s++) begin
                k_cnt[s] = 0;
            end
            exp_q.delete();
            checks = 0;
            errors = 0;
        end else begin
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: response arrived with no request outstanding", $time);
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    checks++;
                    if ({rsp_hit, rsp_fault, rsp_pa} !== want) begin
                        $display("FAIL %0t: got hit %b fault %b pa %h, expected hit %b fault %b pa %h",
                                 $time, rsp_hit, rsp_fault, rsp_pa, want[35], want[34],
                                 want[33:0]);
                        errors++;
                    end
                end
            end
            if (fill_valid && fill_ready && fill_mega) begin
                if (m_cnt == SP_ENTRIES) begin
                    for (int i = 1; i < SP_ENTRIES; i++) begin
                        m_vpn1[i-1] = m_vpn1[i];
                        m_pte[i-1] = m_pte[i];
                    end
                    m_cnt--;
                end
                m_vpn1[m_cnt] = fill_va[31:22];
                m_pte[m_cnt] = fill_pte;
                m_cnt++;
            end else if (fill_valid && fill_ready) begin
                idx = int'(fill_va[31:12]) % TLB_SETS;
                if (k_cnt[idx] == TLB_WAYS) begin
                    for (int i = 1; i < TLB_WAYS; i++) begin
                        k_vpn[idx][i-1] = k_vpn[idx][i];
                        k_pte[idx][i-1] = k_pte[idx][i];
                    end
                    k_cnt[idx]--;
                end
                k_vpn[idx][k_cnt[idx]] = fill_va[31:12];
                k_pte[idx][k_cnt[idx]] = fill_pte;
                k_cnt[idx]++;
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(expect_xlate(req_va, req_write));
            end
        end
        pending = exp_q.size();
    end

endmodule

// File: bench/mmu_tb.sv
module mmu_tb;
    import mmu_pkg::*;

    localparam int TLB_SETS   = 32;
    localparam int TLB_WAYS   = 4;
    localparam int SP_ENTRIES = 4;
    localparam int TIMEOUT    = 200;

    logic             clk = 1'b0;
    logic             rstn;
    logic             req_valid, req_ready, req_write;
    logic [VA_W-1:0]  req_va;
    logic             fill_valid, fill_ready, fill_mega;
    logic [VA_W-1:0]  fill_va;
    logic [PTE_W-1:0] fill_pte;
    logic             rsp_valid, rsp_ready, rsp_hit, rsp_fault;
    logic [PA_W-1:0]  rsp_pa;
    int               checks, errors, pending;
    int               last_checks, last_errors;
    integer           seed = 32'heb9;
    logic [VA_W-1:0]  pages [$];  // base address of every fill.
    bit               bp_on;

    always #20 clk = ~clk;

    mmu_translate #(
        .TLB_SETS   (TLB_SETS),
        .TLB_WAYS   (TLB_WAYS),
        .SP_ENTRIES (SP_ENTRIES)
    ) i_dut (.*);

    mmu_checker #(
        .TLB_SETS   (TLB_SETS),
        .TLB_WAYS   (TLB_WAYS),
        .SP_ENTRIES (SP_ENTRIES)
    ) i_checker (.*);

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic tick();
        @(posedge clk);
        if (bp_on) begin
            rsp_ready <= ($random(seed) & 3) != 0;  // ready about 3 of 4 cycles.
        end
    endtask

    task automatic do_fill(input logic [VA_W-1:0] va, input logic [PTE_W-1:0] pte,
                           input logic mega);
        int n;
        fill_valid <= 1'b1;
        fill_va <= va;
        fill_pte <= pte;
        fill_mega <= mega;
        n = 0;
        do begin
            tick();
            n++;
        end while (!fill_ready && n < TIMEOUT);
        if (!fill_ready) begin
            abort_on_timeout("fill_ready");
        end else begin
            fill_valid <= 1'b0;
            pages.push_back(va);
        end
    endtask

    task automatic do_lookup(input logic [VA_W-1:0] va, input logic write);
        int n;
        req_valid <= 1'b1;
        req_va <= va;
        req_write <= write;
        n = 0;
        do begin
            tick();
            n++;
        end while (!req_ready && n < TIMEOUT);
        if (!req_ready) begin
            abort_on_timeout("req_ready");
        end else begin
            req_valid <= 1'b0;
        end
    endtask

    // drain the responses, then report this test.
    task automatic end_test(input string name);
        int n;
        bp_on = 1'b0;
        rsp_ready <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (pending != 0 && n < TIMEOUT);
        if (pending != 0) begin
            abort_on_timeout("outstanding responses");
        end else begin
            $display("test %-12s %0d checks, %0d errors", name, checks - last_checks,
                     errors - last_errors);
            last_checks = checks;
            last_errors = errors;
            @(posedge clk);
        end
    endtask

    initial begin
        int              base;
        int              idx;
        logic [VA_W-1:0] va;
        rstn = 1'b0;
        req_valid = 1'b0;
        req_va = '0;
        req_write = 1'b0;
        fill_valid = 1'b0;
        fill_va = '0;
        fill_pte = '0;
        fill_mega = 1'b0;
        rsp_ready = 1'b1;
        bp_on = 1'b0;
        last_checks = 0;
        last_errors = 0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < 16; i++) begin
            do_lookup(next_random(), (next_random() & 1) != 0);
        end
        end_test("reset_miss");

        // three pages in each of sets 0 to 7.
        for (int s = 0; s < 8; s++) begin
            for (int w = 0; w < 3; w++) begin
                do_fill({10'(256 + s), 5'(w), 5'(s), 12'h000}, next_random() | 32'h1, 1'b0);
            end
        end
        for (int i = 0; i < pages.size(); i++) begin
            do_lookup(pages[i] | (next_random() & 32'hfff), 1'b0);
        end
        end_test("fill_4k");

        base = pages.size();
        for (int i = 0; i < 5; i++) begin
            do_fill({10'(512 + i), 5'(i), 5'd9, 12'h000}, next_random() | 32'h1, 1'b0);
        end
        for (int i = base; i < pages.size(); i++) begin
            do_lookup(pages[i] | (next_random() & 32'hfff), 1'b0);
        end
        end_test("set_evict");

        // the second megapage covers the 4k pages at vpn1 256.
        base = pages.size();
        for (int i = 0; i < 4; i++) begin
            do_fill({10'(i == 1 ? 256 : 768 + i), 22'h0}, next_random() | 32'h1, 1'b1);
        end
        do_lookup(pages[0] | (next_random() & 32'hfff), 1'b0);
        for (int i = base; i < pages.size(); i++) begin
            do_lookup(pages[i] | (next_random() & 32'h3fffff), 1'b0);
        end
        do_fill({10'd772, 22'h0}, next_random() | 32'h1, 1'b1);
        for (int i = base; i < pages.size(); i++) begin
            do_lookup(pages[i] | (next_random() & 32'h3fffff), 1'b0);
        end
        end_test("megapage");

        base = pages.size();
        do_fill({10'd896, 5'd0, 5'd12, 12'h000}, 32'h1234_500b, 1'b0);  // no W.
        do_fill({10'd897, 5'd1, 5'd12, 12'h000}, 32'h2345_6c06, 1'b0);  // no V.
        do_fill({10'd900, 22'h0}, 32'h3456_780b, 1'b1);
        for (int i = base; i < pages.size(); i++) begin
            do_lookup(pages[i], 1'b1);
            do_lookup(pages[i], 1'b0);
        end
        end_test("fault");

        bp_on = 1'b1;
        for (int i = 0; i < 60; i++) begin
            idx = int'(next_random() % 32'(pages.size()));
            va = ((next_random() & 3) == 0) ? next_random()
                                            : pages[idx] | (next_random() & 32'hfff);
            do_lookup(va, (next_random() & 1) != 0);
        end
        end_test("stream_bp");

        $display("total %0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: mmu_translate.f
source/mmu_pkg.sv
source/tlb_sram.sv
source/tlb.sv
source/superpage_tlb.sv
source/xlate_combine.sv
source/mmu_translate.sv
bench/mmu_assertions.sv
bench/mmu_checker.sv
bench/mmu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module mmu_tb -Mdir obj_dir -f mmu_translate.f
if [ $? -ne 0 ]; then
    echo "verilator build did not complete"
    exit 1
fi

./obj_dir/Vmmu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0

// File: source/mmu_pkg.sv
package mmu_pkg;

    // address widths, Sv32 style.
    localparam int VA_W   = 32;
    localparam int PA_W   = 34;
    localparam int VPN1_W = 10;
    localparam int VPN0_W = 10;
    localparam int VPN_W  = VPN1_W + VPN0_W;

    localparam int PAGE_OFF_W = VA_W - VPN_W;   // 4 KiB page offset.
    localparam int MEGA_OFF_W = VA_W - VPN1_W;  // 4 MiB page offset.

    // pte layout, ppn in the top bits.
    localparam int PTE_W = 32;
    localparam int PPN_W = 22;

    localparam int PTE_V     = 0;
    localparam int PTE_R     = 1;
    localparam int PTE_W_BIT = 2;
    localparam int PTE_X     = 3;

    // one virtual address, read as a 4 KiB or a 4 MiB page.
    typedef union packed {
        struct packed {
            logic [VPN1_W-1:0]     vpn1;
            logic [VPN0_W-1:0]     vpn0;
            logic [PAGE_OFF_W-1:0] offset;
        } page4k;
        struct packed {
            logic [VPN1_W-1:0]     vpn1;
            logic [MEGA_OFF_W-1:0] offset;
        } page4m;
    } va_u;

endpackage

// File: source/mmu_translate.sv
module mmu_translate #(
    parameter int TLB_SETS   = 32,
    parameter int TLB_WAYS   = 4,
    parameter int SP_ENTRIES = 4
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic [mmu_pkg::VA_W-1:0]  req_va,
    input  logic                      req_write,
    input  logic                      fill_valid,
    output logic                      fill_ready,
    input  logic [mmu_pkg::VA_W-1:0]  fill_va,
    input  logic [mmu_pkg::PTE_W-1:0] fill_pte,
    input  logic                      fill_mega,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output logic                      rsp_hit,
    output logic [mmu_pkg::PA_W-1:0]  rsp_pa,
    output logic                      rsp_fault
);
    import mmu_pkg::*;

    logic              tlb_cs;
    logic              tlb_we;
    logic [VPN_W-1:0]  tlb_vpn;
    logic              tlb_hit;
    logic [PTE_W-1:0]  tlb_pte;
    logic              sp_cs;
    logic              sp_we;
    logic [VPN1_W-1:0] sp_vpn1;
    logic              sp_hit;
    logic [PTE_W-1:0]  sp_pte;
    logic [PTE_W-1:0]  pte_in;

    tlb #(
        .TLB_SETS (TLB_SETS),
        .TLB_WAYS (TLB_WAYS)
    ) u_tlb (
        .clk     (clk),
        .rstn    (rstn),
        .cs      (tlb_cs),
        .we      (tlb_we),
        .vpn     (tlb_vpn),
        .pte_in  (pte_in),
        .pte_hit (tlb_hit),
        .pte_out (tlb_pte)
    );

    superpage_tlb #(
        .SP_ENTRIES (SP_ENTRIES)
    ) u_superpage_tlb (
        .clk     (clk),
        .rstn    (rstn),
        .cs      (sp_cs),
        .we      (sp_we),
        .vpn1    (sp_vpn1),
        .pte_in  (pte_in),
        .pte_hit (sp_hit),
        .pte_out (sp_pte)
    );

    xlate_combine u_xlate_combine (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_va     (req_va),
        .req_write  (req_write),
        .fill_valid (fill_valid),
        .fill_va    (fill_va),
        .fill_pte   (fill_pte),
        .fill_mega  (fill_mega),
        .rsp_ready  (rsp_ready),
        .tlb_hit    (tlb_hit),
        .tlb_pte    (tlb_pte),
        .sp_hit     (sp_hit),
        .sp_pte     (sp_pte),
        .req_ready  (req_ready),
        .fill_ready (fill_ready),
        .tlb_cs     (tlb_cs),
        .tlb_we     (tlb_we),
        .tlb_vpn    (tlb_vpn),
        .sp_cs      (sp_cs),
        .sp_we      (sp_we),
        .sp_vpn1    (sp_vpn1),
        .pte_in     (pte_in),
        .rsp_valid  (rsp_valid),
        .rsp_hit    (rsp_hit),
        .rsp_pa     (rsp_pa),
        .rsp_fault  (rsp_fault)
    );

endmodule

// File: source/superpage_tlb.sv
module superpage_tlb #(
    parameter int SP_ENTRIES = 4
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       cs,
    input  logic                       we,
    input  logic [mmu_pkg::VPN1_W-1:0] vpn1,
    input  logic [mmu_pkg::PTE_W-1:0]  pte_in,
    output logic                       pte_hit,
    output logic [mmu_pkg::PTE_W-1:0]  pte_out
);
    import mmu_pkg::*;

    localparam int PTR_W = (SP_ENTRIES > 1) ? $clog2(SP_ENTRIES) : 1;

    logic [SP_ENTRIES-1:0] valid;
    logic [VPN1_W-1:0]     tags [SP_ENTRIES];
    logic [PTE_W-1:0]      ptes [SP_ENTRIES];
    logic [PTR_W-1:0]      wr_ptr;
    logic [SP_ENTRIES-1:0] match;
    logic [PTE_W-1:0]      match_pte;

    // round robin pointer, so the oldest fill goes first.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid  <= '0;
            wr_ptr <= '0;
        end else if (cs && we) begin
            valid[wr_ptr] <= 1'b1;
            wr_ptr        <= (wr_ptr == PTR_W'(SP_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cs && we) begin
            tags[wr_ptr] <= vpn1;
            ptes[wr_ptr] <= pte_in;
        end
    end

    always_comb begin
        match_pte = '0;
        for (int e = 0; e < SP_ENTRIES; e++) begin
            match[e]  = valid[e] && (tags[e] == vpn1);
            match_pte = match_pte | ({PTE_W{match[e]}} & ptes[e]);
        end
    end

    // result held while not selected.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pte_hit <= 1'b0;
        end else if (cs && !we) begin
            pte_hit <= |match;
        end
    end

    always_ff @(posedge clk) begin
        if (cs && !we) begin
            pte_out <= match_pte;
        end
    end

endmodule

// File: source/tlb.sv
module tlb #(
    parameter int TLB_SETS = 32,
    parameter int TLB_WAYS = 4
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      cs,
    input  logic                      we,
    input  logic [mmu_pkg::VPN_W-1:0] vpn,
    input  logic [mmu_pkg::PTE_W-1:0] pte_in,
    output logic                      pte_hit,
    output logic [mmu_pkg::PTE_W-1:0] pte_out
);
    import mmu_pkg::*;

    localparam int IDX_W = $clog2(TLB_SETS);
    localparam int TAG_W = VPN_W - IDX_W;
    localparam int AGE_W = $clog2(TLB_WAYS);

    logic [IDX_W-1:0]               idx;
    logic [TAG_W-1:0]               tag;
    logic [TAG_W-1:0]               tag_q;
    logic                           lookup;
    logic [TLB_WAYS-1:0]            victim;
    logic [TLB_WAYS-1:0]            hit;
    logic [TLB_WAYS-1:0][PTE_W-1:0] way_pte;

    assign idx    = vpn[IDX_W-1:0];
    assign tag    = vpn[VPN_W-1:IDX_W];
    assign lookup = cs && !we;

    // tag compared one cycle later against sram output.
    always_ff @(posedge clk) begin
        if (lookup) begin
            tag_q <= tag;
        end
    end

    for (genvar g = 0; g < TLB_WAYS; g++) begin : g_way
        logic [TLB_SETS-1:0] valid;
        logic [AGE_W-1:0]    age [TLB_SETS];
        logic                valid_q;
        logic [TAG_W-1:0]    tag_out;
        logic                ram_cs;

        // the oldest fill in the set has age zero.
        assign victim[g] = cs && we && (age[idx] == '0);
        assign ram_cs    = lookup || victim[g];  // other ways keep their read data.

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid <= '0;
                for (int s = 0; s < TLB_SETS; s++) begin
                    age[s] <= AGE_W'(g);
                end
            end else if (cs && we) begin
                if (victim[g]) begin
                    valid[idx] <= 1'b1;
                    age[idx]   <= AGE_W'(TLB_WAYS - 1);  // youngest.
                end else begin
                    age[idx] <= age[idx] - 1'b1;
                end
            end
        end

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid_q <= 1'b0;
            end else if (lookup) begin
                valid_q <= valid[idx];
            end
        end

        assign hit[g] = valid_q && (tag_out == tag_q);

        tlb_sram #(
            .DEPTH (TLB_SETS),
            .WIDTH (TAG_W)
        ) u_tag_ram (
            .clk  (clk),
            .cs   (ram_cs),
            .we   (victim[g]),
            .addr (idx),
            .din  (tag),
            .dout (tag_out)
        );

        tlb_sram #(
            .DEPTH (TLB_SETS),
            .WIDTH (PTE_W)
        ) u_pte_ram (
            .clk  (clk),
            .cs   (ram_cs),
            .we   (victim[g]),
            .addr (idx),
            .din  (pte_in),
            .dout (way_pte[g])
        );
    end

    assign pte_hit = |hit;

    // at most one way hits, so an or-tree is enough.
    always_comb begin
        pte_out = '0;
        for (int w = 0; w < TLB_WAYS; w++) begin
            pte_out = pte_out | ({PTE_W{hit[w]}} & way_pte[w]);
        end
    end

endmodule

// File: source/tlb_sram.sv
module tlb_sram #(
    parameter int DEPTH = 32,
    parameter int WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     cs,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         din,
    output logic [WIDTH-1:0]         dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    // dout only moves on a selected read.
    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                mem[addr] <= din;
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

// File: source/xlate_combine.sv
module xlate_combine (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       req_valid,
    input  logic [mmu_pkg::VA_W-1:0]   req_va,
    input  logic                       req_write,
    input  logic                       fill_valid,
    input  logic [mmu_pkg::VA_W-1:0]   fill_va,
    input  logic [mmu_pkg::PTE_W-1:0]  fill_pte,
    input  logic                       fill_mega,
    input  logic                       rsp_ready,
    input  logic                       tlb_hit,
    input  logic [mmu_pkg::PTE_W-1:0]  tlb_pte,
    input  logic                       sp_hit,
    input  logic [mmu_pkg::PTE_W-1:0]  sp_pte,
    output logic                       req_ready,
    output logic                       fill_ready,
    output logic                       tlb_cs,
    output logic                       tlb_we,
    output logic [mmu_pkg::VPN_W-1:0]  tlb_vpn,
    output logic                       sp_cs,
    output logic                       sp_we,
    output logic [mmu_pkg::VPN1_W-1:0] sp_vpn1,
    output logic [mmu_pkg::PTE_W-1:0]  pte_in,
    output logic                       rsp_valid,
    output logic                       rsp_hit,
    output logic [mmu_pkg::PA_W-1:0]   rsp_pa,
    output logic                       rsp_fault
);
    import mmu_pkg::*;

    va_u        req_view;
    va_u        fill_view;
    va_u        va_q;
    logic       write_q;
    logic       stall;
    logic       fill_go;
    logic       req_go;
    logic [PTE_W-1:0] sel_pte;

    assign req_view  = req_va;
    assign fill_view = fill_va;

    // fills win over lookups. nothing moves while a response is stuck.
    assign stall      = rsp_valid && !rsp_ready;
    assign fill_ready = !stall;
    assign req_ready  = !stall && !fill_valid;
    assign fill_go    = fill_valid && fill_ready;
    assign req_go     = req_valid && req_ready;

    assign tlb_cs  = fill_go ? !fill_mega : req_go;
    assign tlb_we  = fill_go;
    assign tlb_vpn = fill_go ? {fill_view.page4k.vpn1, fill_view.page4k.vpn0}
                             : {req_view.page4k.vpn1, req_view.page4k.vpn0};
    assign sp_cs   = fill_go ? fill_mega : req_go;
    assign sp_we   = fill_go;
    assign sp_vpn1 = fill_go ? fill_view.page4m.vpn1 : req_view.page4m.vpn1;
    assign pte_in  = fill_pte;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rsp_valid <= 1'b0;
        end else if (req_go) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_go) begin
            va_q    <= req_view;
            write_q <= req_write;
        end
    end

    // superpage result wins.
    assign sel_pte = sp_hit ? sp_pte : tlb_pte;
    assign rsp_hit = sp_hit || tlb_hit;

    always_comb begin
        if (sp_hit) begin
            rsp_pa = {sel_pte[PTE_W-1 -: PPN_W-VPN0_W], va_q.page4m.offset};
        end else if (tlb_hit) begin
            rsp_pa = {sel_pte[PTE_W-1 -: PPN_W], va_q.page4k.offset};
        end else begin
            rsp_pa = '0;
        end
    end

    assign rsp_fault = rsp_hit && (!sel_pte[PTE_V] || (write_q && !sel_pte[PTE_W_BIT]));

endmodule
